//--- tb.f
+incdir+hdl
hdl/spi_cmd_pkg.sv
hdl/sync_sig.sv
hdl/spi_iff.sv
hdl/cmd_exec.sv
hdl/spi_cmd_top.sv
tb/spi_cmd_props.sv
tb/spi_cmd_tb.sv

//--- tb/spi_cmd_tb.sv
`timescale 1ns/1ps
`include "spi_cmd_defs.svh"

module spi_cmd_tb;

    localparam int HALF      = 4;
    localparam int GAP       = 8;
    localparam int TIMEOUT   = 40;
    localparam int NUM_TESTS = 20;

    logic clk;
    logic nrst;
    logic spi_clk;
    logic spi_ss;
    logic spi_mosi;
    logic spi_miso;

    integer seed;

    string             test_name [NUM_TESTS];
    spi_cmd_pkg::cmd_t test_cmd  [NUM_TESTS];

    // reference register bank
    logic [`SPI_DATA_W-1:0] ref_regs [`SPI_NUM_REGS];

    spi_cmd_top spi_cmd_top_inst (
        .clk      (clk),
        .nrst     (nrst),
        .spi_clk  (spi_clk),
        .spi_ss   (spi_ss),
        .spi_mosi (spi_mosi),
        .spi_miso (spi_miso)
    );

    always #20 clk = ~clk;

    // ##################################################################
    // failure and compare tasks
    // ##################################################################

    task automatic abort_run();
        $display("Simulation finished: FAIL");
        $fatal(1, "stopped at first failure");
    endtask

    task automatic check_rsp(input string name, input spi_cmd_pkg::rsp_t exp,
                             input spi_cmd_pkg::rsp_t act);
        if (act !== exp) begin
            $display("ERROR %s: rsp expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    task automatic check_status(input string name, input spi_cmd_pkg::status_e exp,
                                input spi_cmd_pkg::status_e act);
        if (act !== exp) begin
            $display("ERROR %s: status expected %h actual %h", name, exp, act);
            abort_run();
        end
    endtask

    // ##################################################################
    // command table and reference model
    // ##################################################################

    function automatic spi_cmd_pkg::cmd_t make_cmd(input spi_cmd_pkg::opcode_e op,
                                                   input logic [`SPI_ADDR_W-1:0] addr,
                                                   input logic [`SPI_DATA_W-1:0] data);
        spi_cmd_pkg::cmd_t c;
        c.opcode = op;
        c.addr   = addr;
        c.data   = data;
        return c;
    endfunction

    task automatic set_entry(input int i, input string name, input spi_cmd_pkg::opcode_e op,
                             input logic [`SPI_ADDR_W-1:0] addr,
                             input logic [`SPI_DATA_W-1:0] data);
        test_name[i] = name;
        test_cmd[i]  = make_cmd(op, addr, data);
    endtask

    task automatic fill_table();
        set_entry(0,  "wr_r3",       spi_cmd_pkg::WRITE, 16'd3,  $random(seed));
        set_entry(1,  "wr_r7",       spi_cmd_pkg::WRITE, 16'd7,  $random(seed));
        set_entry(2,  "wr_r12",      spi_cmd_pkg::WRITE, 16'd12, $random(seed));
        set_entry(3,  "wr_r15",      spi_cmd_pkg::WRITE, 16'd15, $random(seed));
        set_entry(4,  "rd_r3",       spi_cmd_pkg::READ,  16'd3,  32'h0);
        set_entry(5,  "rd_r7",       spi_cmd_pkg::READ,  16'd7,  32'h0);
        set_entry(6,  "rd_r12",      spi_cmd_pkg::READ,  16'd12, 32'h0);
        set_entry(7,  "rd_r15",      spi_cmd_pkg::READ,  16'd15, 32'h0);
        set_entry(8,  "wr_r5_big",   spi_cmd_pkg::WRITE, 16'd5,  32'hFFFF_FFF0);
        set_entry(9,  "add_r5_wrap", spi_cmd_pkg::ADD,   16'd5,  32'h0000_0025);
        set_entry(10, "rd_r5_sum",   spi_cmd_pkg::READ,  16'd5,  32'h0);
        set_entry(11, "add_r3",      spi_cmd_pkg::ADD,   16'd3,  $random(seed));
        set_entry(12, "rd_r3_sum",   spi_cmd_pkg::READ,  16'd3,  32'h0);
        set_entry(13, "id",          spi_cmd_pkg::ID,    16'd0,  32'h0);
        set_entry(14, "nop",         spi_cmd_pkg::NOP,   16'd0,  $random(seed));
        set_entry(15, "bad_opcode",  spi_cmd_pkg::opcode_e'(8'h7E), 16'd3, $random(seed));
        set_entry(16, "bad_addr_wr", spi_cmd_pkg::WRITE, 16'd16, $random(seed));
        set_entry(17, "bad_addr_rd", spi_cmd_pkg::READ,  16'h1233, 32'h0);
        set_entry(18, "rd_r3_after", spi_cmd_pkg::READ,  16'd3,  32'h0);
        set_entry(19, "rd_r0_after", spi_cmd_pkg::READ,  16'd0,  32'h0);
    endtask

    // expected response, register bank updated as the DUT should
    task automatic ref_exec(input spi_cmd_pkg::cmd_t c, output spi_cmd_pkg::rsp_t r);
        logic addr_ok;
        addr_ok  = (c.addr < `SPI_NUM_REGS);
        r.status = spi_cmd_pkg::OK;
        r.opcode = c.opcode;
        r.data   = '0;
        case (c.opcode)
            spi_cmd_pkg::NOP: begin
                r.data = '0;
            end
            spi_cmd_pkg::WRITE, spi_cmd_pkg::READ, spi_cmd_pkg::ADD: begin
                if (!addr_ok) begin
                    r.status = spi_cmd_pkg::BAD_ADDR;
                end else if (c.opcode == spi_cmd_pkg::WRITE) begin
                    ref_regs[c.addr] = c.data;
                    r.data = c.data;
                end else if (c.opcode == spi_cmd_pkg::ADD) begin
                    ref_regs[c.addr] = ref_regs[c.addr] + c.data;
                    r.data = ref_regs[c.addr];
                end else begin
                    r.data = ref_regs[c.addr];
                end
            end
            spi_cmd_pkg::ID: begin
                r.data = `SPI_DEVICE_ID;
            end
            default: begin
                r.status = spi_cmd_pkg::BAD_OPCODE;
            end
        endcase
    endtask

    // ##################################################################
    // SPI master, mode 0
    // ##################################################################

    task automatic spi_frame(input spi_cmd_pkg::cmd_t cmd,
                             output logic [`SPI_RSP_W-1:0] miso_bits);
        logic [`SPI_CMD_W-1:0] tx;
        logic [`SPI_RSP_W-1:0] rx;
        int                    nbits;
        int                    waited;
        logic                  seen;
        tx     = cmd;
        rx     = '0;
        nbits  = 0;
        waited = 0;
        seen   = 1'b0;
        @(posedge clk);
        spi_ss <= 1'b0;
        repeat (HALF) @(posedge clk);
        for (int i = `SPI_CMD_W-1; i >= 0; i--) begin
            // mosi moves in the low phase
            @(posedge clk);
            spi_mosi <= tx[i];
            repeat (HALF) @(posedge clk);
            spi_clk <= 1'b1;
            if (nbits < `SPI_RSP_W) begin
                rx = {rx[`SPI_RSP_W-2:0], spi_miso};
            end
            nbits++;
            repeat (HALF) @(posedge clk);
            spi_clk <= 1'b0;
        end
        repeat (HALF) @(posedge clk);
        spi_ss <= 1'b1;
        // executor strobe ends the frame
        while (!seen) begin
            @(negedge clk);
            waited++;
            if (spi_cmd_top_inst.rsp_valid) begin
                seen = 1'b1;
            end else if (waited > TIMEOUT) begin
                $display("Timeout: no response strobe came after the frame ended.");
                abort_run();
            end
        end
        while (waited < GAP) begin
            @(posedge clk);
            waited++;
        end
        miso_bits = rx;
    endtask

    // ##################################################################
    // main sequence
    // ##################################################################

    initial begin
        spi_cmd_pkg::cmd_t     cur;
        spi_cmd_pkg::rsp_t     exp_prev;
        spi_cmd_pkg::rsp_t     got;
        logic [`SPI_RSP_W-1:0] bits;
        string                 prev_name;

        clk      = 1'b0;
        nrst     = 1'b0;
        spi_clk  = 1'b0;
        spi_ss   = 1'b1;
        spi_mosi = 1'b0;
        seed     = 56;
        for (int i = 0; i < `SPI_NUM_REGS; i++) begin
            ref_regs[i] = '0;
        end
        fill_table();

        repeat (3) @(posedge clk);
        nrst <= 1'b1;
        repeat (2) @(posedge clk);
        if (spi_miso !== 1'b1) begin
            $display("ERROR reset_idle: miso expected 1 actual %b", spi_miso);
            abort_run();
        end

        // first frame returns the zero pending response
        exp_prev  = '0;
        prev_name = "after_reset";
        for (int n = 0; n <= NUM_TESTS; n++) begin
            if (n < NUM_TESTS) begin
                cur = test_cmd[n];
            end else begin
                cur = make_cmd(spi_cmd_pkg::NOP, 16'd0, 32'h0);
            end
            spi_frame(cur, bits);
            got = spi_cmd_pkg::rsp_t'(bits);
            check_status(prev_name, exp_prev.status, got.status);
            check_rsp(prev_name, exp_prev, got);
            ref_exec(cur, exp_prev);
            prev_name = (n < NUM_TESTS) ? test_name[n] : "final_nop";
        end

        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

//--- tb/spi_cmd_props.sv
`timescale 1ns/1ps

module spi_cmd_props (
    input logic clk,
    input logic nrst,
    input logic cmd_valid,
    input logic rsp_valid
);

    // command strobe is a single pulse
    no_double_cmd: assert property (
        @(posedge clk) disable iff (!nrst) cmd_valid |=> !cmd_valid
    ) else $error("cmd_valid high for two cycles in a row");

    // executor answers on the very next cycle
    rsp_after_cmd: assert property (
        @(posedge clk) disable iff (!nrst) cmd_valid |=> rsp_valid
    ) else $error("rsp_valid missing one cycle after cmd_valid");

    rsp_only_after_cmd: assert property (
        @(posedge clk) disable iff (!nrst) rsp_valid |-> $past(cmd_valid)
    ) else $error("rsp_valid without cmd_valid on the cycle before");

    // both strobes quiet in reset
    strobes_low_in_reset: assert property (
        @(posedge clk) !nrst |-> (!cmd_valid && !rsp_valid)
    ) else $error("strobe high while nrst is low");

endmodule

bind spi_iff spi_cmd_props spi_iff_props_inst (
    .clk       (clk),
    .nrst      (nrst),
    .cmd_valid (cmd_valid),
    .rsp_valid (rsp_valid)
);

bind cmd_exec spi_cmd_props cmd_exec_props_inst (
    .clk       (clk),
    .nrst      (nrst),
    .cmd_valid (cmd_valid),
    .rsp_valid (rsp_valid)
);

//--- hdl/spi_cmd_top.sv
`timescale 1ns/1ps

module spi_cmd_top (
    input  logic clk,
    input  logic nrst,
    input  logic spi_clk,
    input  logic spi_ss,
    input  logic spi_mosi,
    output logic spi_miso
);

    spi_cmd_pkg::cmd_t cmd;
    logic              cmd_valid;
    spi_cmd_pkg::rsp_t rsp;
    logic              rsp_valid;

    // SPI pins in, command out, response back for the next frame
    spi_iff spi_iff_inst (
        .clk       (clk),
        .nrst      (nrst),
        .spi_clk   (spi_clk),
        .spi_ss    (spi_ss),
        .spi_mosi  (spi_mosi),
        .spi_miso  (spi_miso),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .rsp       (rsp),
        .rsp_valid (rsp_valid)
    );

    // one cycle turnaround
    cmd_exec cmd_exec_inst (
        .clk       (clk),
        .nrst      (nrst),
        .cmd       (cmd),
        .cmd_valid (cmd_valid),
        .rsp       (rsp),
        .rsp_valid (rsp_valid)
    );

endmodule

//--- hdl/cmd_exec.sv
`timescale 1ns/1ps
`include "spi_cmd_defs.svh"

module cmd_exec (
    input  logic              clk,
    input  logic              nrst,
    input  spi_cmd_pkg::cmd_t cmd,
    input  logic              cmd_valid,
    output spi_cmd_pkg::rsp_t rsp,
    output logic              rsp_valid
);

    localparam int AW = $clog2(`SPI_NUM_REGS);

    spi_cmd_pkg::exec_state_e state, state_nxt;

    logic [`SPI_DATA_W-1:0] regs [`SPI_NUM_REGS];

    logic [AW-1:0]          idx;
    logic                   addr_ok;
    logic [`SPI_DATA_W-1:0] cur_val;
    logic [`SPI_DATA_W-1:0] sum_val;

    spi_cmd_pkg::status_e   status;
    logic [`SPI_DATA_W-1:0] rsp_data;
    logic                   wr_en;
    logic [`SPI_DATA_W-1:0] wr_data;

    // ##################################################################
    // decode
    // ##################################################################

    assign idx     = cmd.addr[AW-1:0];
    assign addr_ok = (cmd.addr < `SPI_NUM_REGS);
    assign cur_val = regs[idx];
    // wraps at 32 bits
    assign sum_val = cur_val + cmd.data;

    // address range only matters for the register opcodes
    always_comb begin
        status   = spi_cmd_pkg::OK;
        rsp_data = '0;
        wr_en    = 1'b0;
        wr_data  = cmd.data;
        case (cmd.opcode)
            spi_cmd_pkg::NOP: begin
                rsp_data = '0;
            end
            spi_cmd_pkg::WRITE: begin
                if (!addr_ok) begin
                    status = spi_cmd_pkg::BAD_ADDR;
                end else begin
                    wr_en    = 1'b1;
                    rsp_data = cmd.data;
                end
            end
            spi_cmd_pkg::READ: begin
                if (!addr_ok) begin
                    status = spi_cmd_pkg::BAD_ADDR;
                end else begin
                    rsp_data = cur_val;
                end
            end
            spi_cmd_pkg::ADD: begin
                if (!addr_ok) begin
                    status = spi_cmd_pkg::BAD_ADDR;
                end else begin
                    wr_en    = 1'b1;
                    wr_data  = sum_val;
                    rsp_data = sum_val;
                end
            end
            spi_cmd_pkg::ID: begin
                rsp_data = `SPI_DEVICE_ID;
            end
            default: begin
                status = spi_cmd_pkg::BAD_OPCODE;
            end
        endcase
    end

    // ##################################################################
    // state machine and register bank
    // ##################################################################

    always_comb begin
        state_nxt = state;
        case (state)
            spi_cmd_pkg::IDLE: begin
                if (cmd_valid) begin
                    state_nxt = spi_cmd_pkg::RESPOND;
                end
            end
            spi_cmd_pkg::RESPOND: begin
                state_nxt = cmd_valid ? spi_cmd_pkg::RESPOND : spi_cmd_pkg::IDLE;
            end
            default: begin
                state_nxt = spi_cmd_pkg::IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state <= spi_cmd_pkg::IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            for (int i = 0; i < `SPI_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (cmd_valid && wr_en) begin
            regs[idx] <= wr_data;
        end
    end

    // response built while the command is on the input
    always_ff @(posedge clk) begin
        if (cmd_valid) begin
            rsp.status <= status;
            rsp.opcode <= cmd.opcode;
            rsp.data   <= rsp_data;
        end
    end

    assign rsp_valid = (state == spi_cmd_pkg::RESPOND);

endmodule

//--- hdl/spi_iff.sv
`timescale 1ns/1ps
`include "spi_cmd_defs.svh"

module spi_iff (
    input  logic              clk,
    input  logic              nrst,
    input  logic              spi_clk,
    input  logic              spi_ss,
    input  logic              spi_mosi,
    output logic              spi_miso,
    output spi_cmd_pkg::cmd_t cmd,
    output logic              cmd_valid,
    input  spi_cmd_pkg::rsp_t rsp,
    input  logic              rsp_valid
);

    logic sync_sck, sync_ss, sync_mosi;
    logic last_sck, last_ss;
    logic posedge_sck, negedge_sck, posedge_ss, negedge_ss;

    logic [`SPI_CMD_W-1:0] rx_reg;
    logic [`SPI_RSP_W-1:0] tx_reg;
    spi_cmd_pkg::rsp_t     pend_rsp;

    // ##################################################################
    // pin synchronization and edge detection
    // ##################################################################

    sync_sig #(.reset_val(1'b0)) sync_sck_inst (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_clk),
        .out_sig (sync_sck)
    );

    sync_sig #(.reset_val(1'b1)) sync_ss_inst (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_ss),
        .out_sig (sync_ss)
    );

    sync_sig #(.reset_val(1'b0)) sync_mosi_inst (
        .clk     (clk),
        .nrst    (nrst),
        .in_sig  (spi_mosi),
        .out_sig (sync_mosi)
    );

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            last_sck <= 1'b0;
            last_ss  <= 1'b1;
        end else begin
            last_sck <= sync_sck;
            last_ss  <= sync_ss;
        end
    end

    // sck edges only count inside a frame
    assign posedge_sck = sync_sck & ~last_sck & ~sync_ss;
    assign negedge_sck = ~sync_sck & last_sck & ~sync_ss;
    assign posedge_ss  = sync_ss & ~last_ss;
    assign negedge_ss  = ~sync_ss & last_ss;

    // ##################################################################
    // receive side
    // ##################################################################

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rx_reg <= '0;
        end else if (negedge_ss) begin
            rx_reg <= '0;
        end else if (posedge_sck) begin
            rx_reg <= {rx_reg[`SPI_CMD_W-2:0], sync_mosi};
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            cmd_valid <= 1'b0;
        end else begin
            cmd_valid <= posedge_ss;
        end
    end

    // command word captured as ss goes back high
    always_ff @(posedge clk) begin
        if (posedge_ss) begin
            cmd <= spi_cmd_pkg::cmd_t'(rx_reg);
        end
    end

    // ##################################################################
    // transmit side
    // ##################################################################

    // latest executor result, sent during the next frame
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pend_rsp <= '0;
        end else if (rsp_valid) begin
            pend_rsp <= rsp;
        end
    end

    // MSB goes out at frame start, the rest on each falling sck
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            tx_reg   <= '0;
            spi_miso <= 1'b1;
        end else if (negedge_ss) begin
            tx_reg   <= {pend_rsp[`SPI_RSP_W-2:0], 1'b0};
            spi_miso <= pend_rsp[`SPI_RSP_W-1];
        end else if (posedge_ss) begin
            spi_miso <= 1'b1;
        end else if (negedge_sck) begin
            tx_reg   <= {tx_reg[`SPI_RSP_W-2:0], 1'b0};
            spi_miso <= tx_reg[`SPI_RSP_W-1];
        end
    end

endmodule

//--- hdl/sync_sig.sv
`timescale 1ns/1ps

module sync_sig #(
    // idle level of the sampled pin
    parameter logic reset_val = 1'b0
) (
    input  logic clk,
    input  logic nrst,
    input  logic in_sig,
    output logic out_sig
);

    logic meta;

    // two stages before anything looks at the pin
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            meta    <= reset_val;
            out_sig <= reset_val;
        end else begin
            meta    <= in_sig;
            out_sig <= meta;
        end
    end

endmodule

//--- hdl/spi_cmd_pkg.sv
`include "spi_cmd_defs.svh"

package spi_cmd_pkg;

    // command opcodes, first byte of the frame
    typedef enum logic [`SPI_OP_W-1:0] {
        NOP   = 8'h00,
        WRITE = 8'h01,
        READ  = 8'h02,
        ADD   = 8'h03,
        ID    = 8'h0F
    } opcode_e;

    // response status, first byte of the response
    typedef enum logic [7:0] {
        OK         = 8'h00,
        BAD_OPCODE = 8'h01,
        BAD_ADDR   = 8'h02
    } status_e;

    typedef enum logic {
        IDLE,
        RESPOND
    } exec_state_e;

    // 56 bit command, MSB first on MOSI
    typedef struct packed {
        opcode_e                 opcode;
        logic [`SPI_ADDR_W-1:0]  addr;
        logic [`SPI_DATA_W-1:0]  data;
    } cmd_t;

    // 48 bit response, MSB first on MISO
    typedef struct packed {
        status_e                 status;
        logic [`SPI_OP_W-1:0]    opcode;
        logic [`SPI_DATA_W-1:0]  data;
    } rsp_t;

endpackage

//--- hdl/spi_cmd_defs.svh
`ifndef SPI_CMD_DEFS_SVH
`define SPI_CMD_DEFS_SVH

// frame widths on the wire
`define SPI_CMD_W 56
`define SPI_RSP_W 48

// field widths inside the frames
`define SPI_OP_W 8
`define SPI_ADDR_W 16
`define SPI_DATA_W 32

// register bank size
`define SPI_NUM_REGS 16

// value returned by the ID opcode
`define SPI_DEVICE_ID 32'h5C3D_0A17

`endif
